/* vlog.f */
logic/fetch_pkg.sv
logic/line_refill.sv
logic/line_buffer.sv
logic/inst_queue.sv
logic/fetch_ctrl.sv
logic/fetch_top.sv
bench/fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module fetch_tb -o fetch_tb_sim
./obj_dir/fetch_tb_sim | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    echo "run.sh: passed"
    exit 0
else
    echo "run.sh: failed"
    exit 1
fi

/* bench/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;

    // limit for the whole run in clock cycles
    localparam int timeout_cycles = 20000;

    logic                            clk;
    logic                            rst = 1'b1;
    logic [fetch_pkg::xlen-1:0]      bmem_addr;
    logic                            bmem_read;
    logic                            bmem_ready_i;
    logic                            bmem_rvalid_i;
    logic [fetch_pkg::xlen-1:0]      bmem_raddr_i;
    logic [fetch_pkg::beat_bits-1:0] bmem_rdata_i;
    logic                            redirect_i;
    logic [fetch_pkg::xlen-1:0]      redirect_pc_i;
    logic                            dequeue_i;
    logic                            q_empty;
    fetch_pkg::fetch_entry_t         q_entry;

    // bit 128 marks a restart record {order, pc, 32'h0}
    logic [128:0]                    observed[$];
    logic [fetch_pkg::xlen-1:0]      exp_pc = fetch_pkg::reset_pc;
    logic [63:0]                     exp_order = 64'd0;
    logic [63:0]                     deq_total;
    string                           current_test;
    int                              errors;
    int                              checks;
    int                              tests_run;
    int                              test_errors_start;
    int                              cycles;
    int                              seed_value;

    fetch_top dut (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .dequeue_i     (dequeue_i),
        .q_empty_o     (q_empty),
        .q_entry_o     (q_entry)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory contents as a function of the byte address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return (addr ^ 32'h5a5a5a5a) + (addr << 7);
    endfunction

    function automatic fetch_pkg::fetch_entry_t expected_entry(input logic [31:0] pc,
                                                               input logic [63:0] order);
        fetch_pkg::fetch_entry_t e;
        e.order = order;
        e.pc    = pc;
        e.inst  = mem_word(pc);
        return e;
    endfunction

    task automatic check_value(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error %s: %s expected %h actual %h", current_test, what,
                     expected, actual);
        end
    endtask

    task automatic begin_test(input string name);
        current_test      = name;
        test_errors_start = errors;
    endtask

    task automatic end_test;
        while (observed.size() != 0) begin
            @(negedge clk);
        end
        tests_run++;
        if (errors == test_errors_start) begin
            $display("test %s: ok", current_test);
        end else begin
            $display("test %s: %0d errors", current_test, errors - test_errors_start);
        end
    endtask

    // dequeue whenever the queue is not empty until n entries are taken
    task automatic consume(input int n);
        int taken;
        taken = 0;
        while (taken < n) begin
            @(negedge clk);
            if (!q_empty) begin
                dequeue_i = 1'b1;
                observed.push_back({1'b0, q_entry});
                deq_total = deq_total + 64'd1;
                taken++;
            end else begin
                dequeue_i = 1'b0;
            end
        end
        @(negedge clk);
        dequeue_i = 1'b0;
    endtask

    task automatic redirect_to(input logic [31:0] target, input logic with_deq);
        @(negedge clk);
        redirect_i    = 1'b1;
        redirect_pc_i = target;
        if (with_deq && !q_empty) begin
            dequeue_i = 1'b1;
            observed.push_back({1'b0, q_entry});
            deq_total = deq_total + 64'd1;
        end else begin
            dequeue_i = 1'b0;
        end
        observed.push_back({1'b1, deq_total, target, 32'h0});
        @(negedge clk);
        redirect_i = 1'b0;
        dequeue_i  = 1'b0;
    endtask

    task automatic wait_for_request(input logic [31:0] line_addr);
        @(negedge clk);
        while (!(bmem_read && bmem_addr == line_addr)) begin
            @(negedge clk);
        end
    endtask

    // expected pc and order follow the fetch rules
    initial begin : compare_stream
        logic [128:0]            rec;
        fetch_pkg::fetch_entry_t exp_e;
        forever begin
            @(posedge clk);
            while (observed.size() > 0) begin
                rec = observed.pop_front();
                if (rec[128]) begin
                    exp_order = rec[127:64];
                    exp_pc    = rec[63:32];
                end else begin
                    exp_e = expected_entry(exp_pc, exp_order);
                    check_value("entry", exp_e, rec[127:0]);
                    exp_pc    = exp_pc + 32'd4;
                    exp_order = exp_order + 64'd1;
                end
            end
        end
    end

    // burst memory with random accept delay and rotated beats
    initial begin : memory_model
        int          wait_cycles;
        int          first;
        logic [31:0] req_addr;
        logic [31:0] beat_addr;
        bmem_ready_i  = 1'b0;
        bmem_rvalid_i = 1'b0;
        bmem_raddr_i  = '0;
        bmem_rdata_i  = '0;
        wait (!rst);
        forever begin
            @(negedge clk);
            if (bmem_read) begin
                req_addr = bmem_addr;
                check_value("request alignment", 128'd0, 128'(req_addr[4:0]));
                wait_cycles = $urandom_range(3, 0);
                repeat (wait_cycles) begin
                    @(negedge clk);
                    check_value("request held", 128'd1, 128'(bmem_read));
                end
                bmem_ready_i = 1'b1;
                @(negedge clk);
                bmem_ready_i = 1'b0;
                check_value("request dropped", 128'd0, 128'(bmem_read));
                first = $urandom_range(3, 0);
                for (int b = 0; b < fetch_pkg::beats_per_line; b++) begin
                    wait_cycles = $urandom_range(2, 0);
                    repeat (wait_cycles) @(negedge clk);
                    beat_addr     = req_addr + 32'(((first + b) % 4) * 8);
                    bmem_rvalid_i = 1'b1;
                    bmem_raddr_i  = beat_addr;
                    bmem_rdata_i  = {mem_word(beat_addr + 32'd4), mem_word(beat_addr)};
                    // no new request may start while this burst returns
                    check_value("request during burst", 128'd0, 128'(bmem_read));
                    @(negedge clk);
                    bmem_rvalid_i = 1'b0;
                end
            end
        end
    end

    initial begin : cycle_limit
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        seed_value    = $urandom(32'h365a65cb);
        rst           = 1'b1;
        dequeue_i     = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        deq_total     = 64'd0;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;

        begin_test("reset_state");
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("read during reset", 128'd0, 128'(bmem_read));
        check_value("empty during reset", 128'd1, 128'(q_empty));
        rst = 1'b0;
        @(negedge clk);
        check_value("read after reset", 128'd0, 128'(bmem_read));
        check_value("empty after reset", 128'd1, 128'(q_empty));
        consume(1);
        end_test();

        begin_test("sequential_fetch");
        consume(32);
        end_test();

        begin_test("back_pressure");
        repeat (40) @(negedge clk);
        check_value("queue holds entries", 128'd0, 128'(q_empty));
        consume(20);
        end_test();

        begin_test("redirect_with_entries");
        while (q_empty) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        redirect_to(32'haaab0214, 1'b1);
        consume(12);
        end_test();

        begin_test("redirect_during_refill");
        redirect_to(32'haaac0008, 1'b0);
        wait_for_request(32'haaac0000);
        // same line as the refill in flight
        redirect_to(32'haaac0010, 1'b0);
        consume(12);
        redirect_to(32'haaad0104, 1'b0);
        wait_for_request(32'haaad0100);
        redirect_to(32'haaae0218, 1'b0);
        consume(12);
        end_test();

        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* logic/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
    input  logic                            clk,
    input  logic                            rst,

    output logic [fetch_pkg::xlen-1:0]      bmem_addr_o,
    output logic                            bmem_read_o,
    input  logic                            bmem_ready_i,
    input  logic                            bmem_rvalid_i,
    input  logic [fetch_pkg::xlen-1:0]      bmem_raddr_i,
    input  logic [fetch_pkg::beat_bits-1:0] bmem_rdata_i,

    input  logic                            redirect_i,
    input  logic [fetch_pkg::xlen-1:0]      redirect_pc_i,
    input  logic                            dequeue_i,
    output logic                            q_empty_o,
    output fetch_pkg::fetch_entry_t         q_entry_o
);

    logic                            fill_req;
    logic [fetch_pkg::xlen-1:0]      fill_addr;
    logic                            fill_done;
    logic [fetch_pkg::line_bits-1:0] fill_line;
    logic [fetch_pkg::xlen-1:0]      fill_line_addr;
    logic                            lb_hit;
    logic [fetch_pkg::xlen-1:0]      lb_word;
    logic                            q_full;
    logic                            enq;
    fetch_pkg::fetch_entry_t         enq_entry;
    logic [fetch_pkg::xlen-1:0]      fetch_pc;

    // line lookup follows the live fetch pc
    assign fetch_pc = u_ctrl.pc;

    fetch_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .dequeue_i     (dequeue_i),
        .lb_hit_i      (lb_hit),
        .lb_word_i     (lb_word),
        .q_full_i      (q_full),
        .fill_done_i   (fill_done),
        .fill_req_o    (fill_req),
        .fill_addr_o   (fill_addr),
        .enq_o         (enq),
        .entry_o       (enq_entry)
    );

    line_refill u_refill (
        .clk              (clk),
        .rst              (rst),
        .fill_req_i       (fill_req),
        .fill_addr_i      (fill_addr),
        .bmem_ready_i     (bmem_ready_i),
        .bmem_rvalid_i    (bmem_rvalid_i),
        .bmem_raddr_i     (bmem_raddr_i),
        .bmem_rdata_i     (bmem_rdata_i),
        .bmem_addr_o      (bmem_addr_o),
        .bmem_read_o      (bmem_read_o),
        .fill_done_o      (fill_done),
        .fill_line_o      (fill_line),
        .fill_line_addr_o (fill_line_addr)
    );

    line_buffer u_line_buf (
        .clk              (clk),
        .rst              (rst),
        .fill_done_i      (fill_done),
        .fill_line_i      (fill_line),
        .fill_line_addr_i (fill_line_addr),
        .pc_i             (fetch_pc),
        .hit_o            (lb_hit),
        .word_o           (lb_word)
    );

    inst_queue u_queue (
        .clk     (clk),
        .rst     (rst),
        .flush_i (redirect_i),
        .enq_i   (enq),
        .entry_i (enq_entry),
        .deq_i   (dequeue_i),
        .entry_o (q_entry_o),
        .full_o  (q_full),
        .empty_o (q_empty_o)
    );

endmodule

/* logic/fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         redirect_i,
    input  logic [fetch_pkg::xlen-1:0]   redirect_pc_i,
    input  logic                         dequeue_i,
    input  logic                         lb_hit_i,
    input  logic [fetch_pkg::xlen-1:0]   lb_word_i,
    input  logic                         q_full_i,
    input  logic                         fill_done_i,
    output logic                         fill_req_o,
    output logic [fetch_pkg::xlen-1:0]   fill_addr_o,
    output logic                         enq_o,
    output fetch_pkg::fetch_entry_t      entry_o
);

    logic [fetch_pkg::xlen-1:0]       pc;
    logic [fetch_pkg::order_bits-1:0] order;
    logic [fetch_pkg::order_bits-1:0] deq_count;
    logic [fetch_pkg::order_bits-1:0] restart_order;
    logic                             refill_busy;
    logic                             take_hit;
    logic                             start_fill;

    assign take_hit   = !redirect_i && lb_hit_i && !q_full_i;
    assign start_fill = !redirect_i && !lb_hit_i && !refill_busy;

    // includes a dequeue in the redirect cycle itself
    assign restart_order = deq_count + {{(fetch_pkg::order_bits - 1){1'b0}}, dequeue_i};

    always_ff @(posedge clk) begin
        if (rst) begin
            deq_count <= '0;
        end else if (dequeue_i) begin
            deq_count <= deq_count + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= fetch_pkg::reset_pc;
            order       <= '0;
            enq_o       <= 1'b0;
            fill_req_o  <= 1'b0;
            refill_busy <= 1'b0;
        end else begin
            enq_o      <= 1'b0;
            fill_req_o <= 1'b0;

            // a refill in flight always runs to completion
            if (fill_done_i) begin
                refill_busy <= 1'b0;
            end

            if (redirect_i) begin
                pc    <= redirect_pc_i;
                order <= restart_order;
            end else if (take_hit) begin
                enq_o <= 1'b1;
                pc    <= pc + 32'd4;
                order <= order + 64'd1;
            end else if (start_fill) begin
                fill_req_o  <= 1'b1;
                refill_busy <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_hit) begin
            entry_o <= '{order: order, pc: pc, inst: lb_word_i};
        end
        if (start_fill) begin
            fill_addr_o <= pc;
        end
    end

endmodule

/* logic/inst_queue.sv */
`timescale 1ns/1ps

module inst_queue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush_i,
    input  logic                    enq_i,
    input  fetch_pkg::fetch_entry_t entry_i,
    input  logic                    deq_i,
    output fetch_pkg::fetch_entry_t entry_o,
    output logic                    full_o,
    output logic                    empty_o
);

    fetch_pkg::fetch_entry_t slots [fetch_pkg::queue_depth];
    fetch_pkg::queue_ptr_t   rd_ptr;
    fetch_pkg::queue_ptr_t   wr_ptr;
    fetch_pkg::queue_cnt_t   count;
    logic                    at_limit;
    logic                    do_enq;
    logic                    do_deq;

    assign at_limit = (count == fetch_pkg::queue_cnt_t'(fetch_pkg::queue_depth));
    assign do_enq   = enq_i && !at_limit;
    assign do_deq   = deq_i && !empty_o;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            slots[wr_ptr] <= entry_i;
        end
    end

    assign entry_o = slots[rd_ptr];
    assign empty_o = (count == '0);

    // the producer registers its push, so a push in flight already
    // takes the last free slot
    assign full_o = at_limit ||
                    (enq_i &&
                     count == fetch_pkg::queue_cnt_t'(fetch_pkg::queue_depth - 1));

endmodule

/* logic/line_buffer.sv */
`timescale 1ns/1ps

module line_buffer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            fill_done_i,
    input  logic [fetch_pkg::line_bits-1:0] fill_line_i,
    input  logic [fetch_pkg::xlen-1:0]      fill_line_addr_i,
    input  logic [fetch_pkg::xlen-1:0]      pc_i,
    output logic                            hit_o,
    output logic [fetch_pkg::xlen-1:0]      word_o
);

    logic                                                line_valid;
    logic [fetch_pkg::xlen-1:fetch_pkg::line_tag_lsb]    line_tag;
    logic [fetch_pkg::line_bits-1:0]                     line_data;
    logic [fetch_pkg::line_tag_lsb-1:fetch_pkg::word_sel_lsb] word_sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            line_valid <= 1'b0;
        end else if (fill_done_i) begin
            line_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done_i) begin
            line_tag  <= fill_line_addr_i[fetch_pkg::xlen-1:fetch_pkg::line_tag_lsb];
            line_data <= fill_line_i;
        end
    end

    assign word_sel = pc_i[fetch_pkg::line_tag_lsb-1:fetch_pkg::word_sel_lsb];

    assign hit_o  = line_valid &&
                    (line_tag == pc_i[fetch_pkg::xlen-1:fetch_pkg::line_tag_lsb]);
    assign word_o = line_data[word_sel * fetch_pkg::xlen +: fetch_pkg::xlen];

endmodule

/* logic/line_refill.sv */
`timescale 1ns/1ps

module line_refill (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            fill_req_i,
    input  logic [fetch_pkg::xlen-1:0]      fill_addr_i,
    input  logic                            bmem_ready_i,
    input  logic                            bmem_rvalid_i,
    input  logic [fetch_pkg::xlen-1:0]      bmem_raddr_i,
    input  logic [fetch_pkg::beat_bits-1:0] bmem_rdata_i,
    output logic [fetch_pkg::xlen-1:0]      bmem_addr_o,
    output logic                            bmem_read_o,
    output logic                            fill_done_o,
    output logic [fetch_pkg::line_bits-1:0] fill_line_o,
    output logic [fetch_pkg::xlen-1:0]      fill_line_addr_o
);

    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_collect
    } refill_state_t;

    refill_state_t                   state;
    fetch_pkg::beat_sel_t            beat_cnt;
    fetch_pkg::beat_sel_t            beat_idx;
    logic [fetch_pkg::xlen-1:0]      line_addr;
    logic [fetch_pkg::line_bits-1:0] line_data;

    assign beat_idx = bmem_raddr_i[fetch_pkg::beat_sel_lsb +: fetch_pkg::beat_sel_bits];

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_idle;
            beat_cnt    <= '0;
            fill_done_o <= 1'b0;
        end else begin
            fill_done_o <= 1'b0;
            case (state)
                st_idle: begin
                    if (fill_req_i) begin
                        state <= st_request;
                    end
                end
                // hold read until memory takes it
                st_request: begin
                    if (bmem_ready_i) begin
                        state <= st_collect;
                    end
                end
                st_collect: begin
                    if (bmem_rvalid_i) begin
                        if (beat_cnt == fetch_pkg::beat_sel_t'(fetch_pkg::beats_per_line - 1)) begin
                            beat_cnt    <= '0;
                            fill_done_o <= 1'b1;
                            state       <= st_idle;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && fill_req_i) begin
            line_addr <= {fill_addr_i[fetch_pkg::xlen-1:fetch_pkg::line_tag_lsb],
                          {fetch_pkg::line_tag_lsb{1'b0}}};
        end
        // beats land by their own address, not arrival order
        if (state == st_collect && bmem_rvalid_i) begin
            line_data[beat_idx * fetch_pkg::beat_bits +: fetch_pkg::beat_bits] <= bmem_rdata_i;
        end
    end

    assign bmem_read_o      = (state == st_request);
    assign bmem_addr_o      = line_addr;
    assign fill_line_addr_o = line_addr;
    assign fill_line_o      = line_data;

endmodule

/* logic/fetch_pkg.sv */
package fetch_pkg;

    // datapath and memory widths
    localparam int xlen           = 32;
    localparam int line_bits      = 256;
    localparam int beat_bits      = 64;
    localparam int beats_per_line = 4;

    // pc bits 31:5 tag a line, 4:2 pick the word
    localparam int line_tag_lsb   = 5;
    localparam int word_sel_lsb   = 2;

    // return address bits that place a beat in the line
    localparam int beat_sel_lsb   = 3;
    localparam int beat_sel_bits  = $clog2(beats_per_line);

    localparam logic [xlen-1:0] reset_pc = 32'haaaaa000;

    localparam int queue_depth    = 8;
    localparam int queue_ptr_bits = $clog2(queue_depth);
    localparam int queue_cnt_bits = queue_ptr_bits + 1;

    localparam int order_bits     = 64;

    typedef logic [beat_sel_bits-1:0]  beat_sel_t;
    typedef logic [queue_ptr_bits-1:0] queue_ptr_t;
    typedef logic [queue_cnt_bits-1:0] queue_cnt_t;

    // 128 bits, order in the top half
    typedef struct packed {
        logic [order_bits-1:0] order;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       inst;
    } fetch_entry_t;

endpackage
